/* adc_timing_cfg.svh */
`ifndef ADC_TIMING_CFG_SVH
`define ADC_TIMING_CFG_SVH

//////////////////////////////////////////////////////////////////////
// fixed sequencer timing, all counts in fastClk cycles
//////////////////////////////////////////////////////////////////////

// adc warm-up after power-up, 9.24 us at a 2.8 ns clock
`define SEQ_WARMUP_CYCLES 3300

// alignment phase length
`define SEQ_ALIGN_CYCLES 10000

// front-panel led pulse length
`define SEQ_LED_CYCLES 31

// ring clock synchroniser depth
`define SEQ_SYNC_STAGES 2

`endif

/* adc_timing_pkg.sv */
package adc_timing_pkg;

	//////////////////////////////////////////////////////////////////////
	// configuration words
	//////////////////////////////////////////////////////////////////////

	// sync pulses from trigger to adc power-up
	typedef logic [11:0] trig_delay_t;
	// store strobe start offset in samples
	typedef logic [6:0] hold_off_t;
	// store strobe length in samples
	typedef logic [9:0] num_smpls_t;
	// sync pulse period minus one
	typedef logic [7:0] sync_period_t;

	//////////////////////////////////////////////////////////////////////
	// internal counters
	//////////////////////////////////////////////////////////////////////

	// wide enough for hold-off plus sample count
	typedef logic [10:0] sample_count_t;
	typedef logic [13:0] align_count_t;
	// led stretcher counter
	typedef logic [4:0] led_count_t;

	// acquisition fsm, one-hot
	typedef enum logic [3:0] {
		SEQ_IDLE     = 4'b0001,
		SEQ_WARM_UP  = 4'b0010,
		SEQ_SAMPLING = 4'b0100,
		SEQ_ALIGN    = 4'b1000
	} seq_state_e;

endpackage

/* adc_phase_if.sv */
`timescale 1ns/1ns

// phase handshake between the sequencer and the two phase timers
// enables are levels, done signals are single-cycle pulses
interface adc_phase_if;

	// sampling window enable, held until sampling_done
	logic sample_en;
	// end of store strobe
	logic sampling_done;
	// alignment enable, held until align_done
	logic align_en;
	// end of alignment count
	logic align_done;

	// acquisition fsm side
	modport seq (
		output sample_en,
		output align_en,
		input  sampling_done,
		input  align_done
	);

	// store strobe generator side
	modport window (
		input  sample_en,
		output sampling_done
	);

	// alignment timer side
	modport align (
		input  align_en,
		output align_done
	);

endinterface

/* ring_sync.sv */
`timescale 1ns/1ns

`include "adc_timing_cfg.svh"

module ring_sync import adc_timing_pkg::*; (
	input  logic         fastClk,
	input  logic         rst_n,
	input  logic         ring_clk,
	input  logic         ring_edge_sel,
	input  logic         use_ext_ring,
	input  sync_period_t sync_period,
	output logic         trig_sync
);

	//////////////////////////////////////////////////////////////////////
	// ring clock synchroniser and edge detect
	//////////////////////////////////////////////////////////////////////

	logic [`SEQ_SYNC_STAGES-1:0] ring_meta;
	logic                        ring_now;
	logic                        ring_dly;
	logic                        ring_edge;

	always_ff @(posedge fastClk) begin
		if (!rst_n) begin
			ring_meta <= '0;
			ring_dly  <= 1'b0;
		end else begin
			// shift chain, bit 0 takes the raw pin
			ring_meta[0] <= ring_clk;
			for (int i = 1; i < `SEQ_SYNC_STAGES; i++) begin
				ring_meta[i] <= ring_meta[i-1];
			end
			// extra flop for the edge compare
			ring_dly <= ring_now;
		end
	end

	assign ring_now = ring_meta[`SEQ_SYNC_STAGES-1];

	// high sel picks rising edges, low sel falling
	assign ring_edge = ring_edge_sel ? (ring_now & ~ring_dly) : (~ring_now & ring_dly);

	//////////////////////////////////////////////////////////////////////
	// start latch and sync pulse generator
	//////////////////////////////////////////////////////////////////////

	logic         started;
	sync_period_t period_ctr;

	always_ff @(posedge fastClk) begin
		if (!rst_n) begin
			started    <= 1'b0;
			period_ctr <= '0;
			trig_sync  <= 1'b0;
		end else begin
			// external mode waits for first selected edge
			// internal mode starts straight away
			if (!started) begin
				started <= use_ext_ring ? ring_edge : 1'b1;
			end
			if (!started) begin
				period_ctr <= '0;
				trig_sync  <= 1'b0;
			end else if (period_ctr == sync_period) begin
				// wrap, one pulse per period
				period_ctr <= '0;
				trig_sync  <= 1'b1;
			end else begin
				period_ctr <= period_ctr + 1'b1;
				trig_sync  <= 1'b0;
			end
		end
	end

endmodule

/* trig_sequencer.sv */
`timescale 1ns/1ns

`include "adc_timing_cfg.svh"

module trig_sequencer import adc_timing_pkg::*; (
	input  logic            fastClk,
	input  logic            rst_n,
	input  logic            trig,
	input  logic            trig_sync,
	input  trig_delay_t     trig_delay,
	adc_phase_if.seq        phase,
	output logic            adc_powerup
);

	// warm-up counter sized from the configured length
	localparam int WARM_W = $clog2(`SEQ_WARMUP_CYCLES + 1);
	localparam logic [WARM_W-1:0] WARM_LAST = WARM_W'(`SEQ_WARMUP_CYCLES);

	seq_state_e        state;
	logic              triggered;
	trig_delay_t       trig_count;
	logic [WARM_W-1:0] warm_ctr;

	//////////////////////////////////////////////////////////////////////
	// trigger delay and acquisition fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fastClk) begin
		if (!rst_n) begin
			state           <= SEQ_IDLE;
			triggered       <= 1'b0;
			trig_count      <= '0;
			warm_ctr        <= '0;
			adc_powerup     <= 1'b0;
			phase.sample_en <= 1'b0;
			phase.align_en  <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					warm_ctr <= '0;
					if (!triggered) begin
						// arm on trig level, count restarts
						triggered  <= trig;
						trig_count <= '0;
					end else if (trig_count == trig_delay) begin
						// delay reached so power the adc up
						state       <= SEQ_WARM_UP;
						adc_powerup <= 1'b1;
					end else if (trig_sync) begin
						trig_count <= trig_count + 1'b1;
					end
				end
				SEQ_WARM_UP: begin
					// fixed settle time before sampling
					if (warm_ctr == WARM_LAST) begin
						state           <= SEQ_SAMPLING;
						phase.sample_en <= 1'b1;
					end else begin
						warm_ctr <= warm_ctr + 1'b1;
					end
				end
				SEQ_SAMPLING: begin
					// window runs in sample_window
					if (phase.sampling_done) begin
						state           <= SEQ_ALIGN;
						phase.sample_en <= 1'b0;
						phase.align_en  <= 1'b1;
					end
				end
				SEQ_ALIGN: begin
					// align timer ends the sequence
					if (phase.align_done) begin
						state          <= SEQ_IDLE;
						triggered      <= 1'b0;
						phase.align_en <= 1'b0;
						adc_powerup    <= 1'b0;
					end
				end
				default: begin
					// illegal one-hot code, back to idle with adc off
					state           <= SEQ_IDLE;
					triggered       <= 1'b0;
					adc_powerup     <= 1'b0;
					phase.sample_en <= 1'b0;
					phase.align_en  <= 1'b0;
				end
			endcase
		end
	end

endmodule

/* sample_window.sv */
`timescale 1ns/1ns

module sample_window import adc_timing_pkg::*; (
	input  logic          fastClk,
	input  logic          rst_n,
	input  hold_off_t     sample_hold_off,
	input  num_smpls_t    num_smpls,
	adc_phase_if.window   phase,
	output logic          store_strb
);

	logic          sample_en_d;
	logic          sample_rise;
	logic          counting;
	sample_count_t sample_count;
	// window edges, recomputed every cycle
	sample_count_t start_pos;
	sample_count_t end_pos;

	// registered to keep the adder off the compare path
	always_ff @(posedge fastClk) begin
		start_pos <= sample_count_t'(sample_hold_off);
		end_pos   <= sample_count_t'(sample_hold_off) + sample_count_t'(num_smpls);
	end

	assign sample_rise = phase.sample_en & ~sample_en_d;

	//////////////////////////////////////////////////////////////////////
	// sample counter and store strobe
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fastClk) begin
		if (!rst_n) begin
			sample_en_d         <= 1'b0;
			counting            <= 1'b0;
			sample_count        <= '0;
			store_strb          <= 1'b0;
			phase.sampling_done <= 1'b0;
		end else begin
			sample_en_d         <= phase.sample_en;
			phase.sampling_done <= 1'b0;
			if (!counting) begin
				// wait for enable edge
				counting     <= sample_rise;
				sample_count <= '0;
			end else begin
				sample_count <= sample_count + 1'b1;
				// end wins so zero samples gives no strobe
				if (sample_count == end_pos) begin
					counting            <= 1'b0;
					store_strb          <= 1'b0;
					phase.sampling_done <= 1'b1;
				end else if (sample_count == start_pos) begin
					store_strb <= 1'b1;
				end
			end
		end
	end

endmodule

/* align_timer.sv */
`timescale 1ns/1ns

`include "adc_timing_cfg.svh"

module align_timer import adc_timing_pkg::*; (
	input  logic       fastClk,
	input  logic       rst_n,
	adc_phase_if.align phase
);

	// counter starts at 1 on the cycle after the enable edge
	localparam align_count_t ALIGN_LAST = align_count_t'(`SEQ_ALIGN_CYCLES - 1);

	logic         align_en_d;
	logic         counting;
	align_count_t align_ctr;

	always_ff @(posedge fastClk) begin
		if (!rst_n) begin
			align_en_d       <= 1'b0;
			counting         <= 1'b0;
			align_ctr        <= '0;
			phase.align_done <= 1'b0;
		end else begin
			align_en_d       <= phase.align_en;
			phase.align_done <= 1'b0;
			if (!counting) begin
				// rising edge of the enable only
				counting  <= phase.align_en & ~align_en_d;
				align_ctr <= align_count_t'(1);
			end else if (align_ctr == ALIGN_LAST) begin
				// single done pulse then rearm
				counting         <= 1'b0;
				phase.align_done <= 1'b1;
			end else begin
				align_ctr <= align_ctr + 1'b1;
			end
		end
	end

endmodule

/* led_stretch.sv */
`timescale 1ns/1ns

`include "adc_timing_cfg.svh"

module led_stretch import adc_timing_pkg::*; (
	input  logic fastClk,
	input  logic rst_n,
	input  logic event_in,
	output logic led
);

	localparam led_count_t LED_LAST = led_count_t'(`SEQ_LED_CYCLES);

	// zero means idle and ready for an event
	led_count_t led_ctr;

	always_ff @(posedge fastClk) begin
		if (!rst_n) begin
			led_ctr <= '0;
			led     <= 1'b0;
		end else if (led_ctr == '0) begin
			// start pulse on next cycle
			if (event_in) begin
				led_ctr <= led_count_t'(1);
				led     <= 1'b1;
			end
		end else if (led_ctr == LED_LAST) begin
			// pulse over
			led_ctr <= '0;
			led     <= 1'b0;
		end else begin
			// events in here are dropped
			led_ctr <= led_ctr + 1'b1;
		end
	end

endmodule

/* adc_timing_top.sv */
`timescale 1ns/1ns

module adc_timing_top import adc_timing_pkg::*; (
	input  logic         fastClk,
	input  logic         rst_n,
	input  logic         ring_clk,
	input  logic         ring_edge_sel,
	input  logic         use_ext_ring,
	input  logic         trig,
	input  sync_period_t sync_period,
	input  trig_delay_t  trig_delay,
	input  hold_off_t    sample_hold_off,
	input  num_smpls_t   num_smpls,
	output logic         store_strb,
	output logic         adc_powerup,
	output logic         adc_align_en,
	output logic         trig_led,
	output logic         ring_led
);

	// one pulse per ring period
	logic trig_sync;

	// phase enables and done pulses
	adc_phase_if phase_if ();

	//////////////////////////////////////////////////////////////////////
	// timing chain
	//////////////////////////////////////////////////////////////////////

	ring_sync u_ring_sync (
		.fastClk       (fastClk),
		.rst_n         (rst_n),
		.ring_clk      (ring_clk),
		.ring_edge_sel (ring_edge_sel),
		.use_ext_ring  (use_ext_ring),
		.sync_period   (sync_period),
		.trig_sync     (trig_sync)
	);

	trig_sequencer u_trig_sequencer (
		.fastClk     (fastClk),
		.rst_n       (rst_n),
		.trig        (trig),
		.trig_sync   (trig_sync),
		.trig_delay  (trig_delay),
		.phase       (phase_if),
		.adc_powerup (adc_powerup)
	);

	sample_window u_sample_window (
		.fastClk         (fastClk),
		.rst_n           (rst_n),
		.sample_hold_off (sample_hold_off),
		.num_smpls       (num_smpls),
		.phase           (phase_if),
		.store_strb      (store_strb)
	);

	align_timer u_align_timer (
		.fastClk (fastClk),
		.rst_n   (rst_n),
		.phase   (phase_if)
	);

	// align enable leaves the chip as is
	assign adc_align_en = phase_if.align_en;

	//////////////////////////////////////////////////////////////////////
	// front-panel leds
	//////////////////////////////////////////////////////////////////////

	led_stretch u_trig_led (
		.fastClk  (fastClk),
		.rst_n    (rst_n),
		.event_in (trig),
		.led      (trig_led)
	);

	led_stretch u_ring_led (
		.fastClk  (fastClk),
		.rst_n    (rst_n),
		.event_in (trig_sync),
		.led      (ring_led)
	);

endmodule

/* tb_adc_timing.sv */
`timescale 1ns/1ns

`include "adc_timing_cfg.svh"

module tb_adc_timing import adc_timing_pkg::*; ();

	localparam int NROWS        = 6;
	localparam int CLK_NS       = 100;
	localparam int QUIET_CYCLES = 40;

	logic         fastClk = 1'b0;
	logic         rst_n;
	logic         ring_clk;
	logic         ring_edge_sel;
	logic         use_ext_ring;
	logic         trig;
	sync_period_t sync_period;
	trig_delay_t  trig_delay;
	hold_off_t    sample_hold_off;
	num_smpls_t   num_smpls;
	logic         store_strb;
	logic         adc_powerup;
	logic         adc_align_en;
	logic         trig_led;
	logic         ring_led;

	// test table, one entry per row
	string row_name   [NROWS];
	int    row_ext    [NROWS];
	int    row_sel    [NROWS];
	int    row_period [NROWS];
	int    row_delay  [NROWS];
	int    row_hold   [NROWS];
	int    row_smpls  [NROWS];

	// ring clock control, owned by main process
	logic ring_run  = 1'b0;
	logic ring_rest = 1'b0;
	int   ring_left = 0;
	int   seed      = 15749;

	// event log, written only by the monitor
	int cyc         = 0;
	int pu_rise     = 0;
	int pu_fall     = 0;
	int strb_rise   = 0;
	int strb_fall   = 0;
	int strb_pulses = 0;
	int align_rise  = 0;
	int align_fall  = 0;
	int led_rise    = 0;
	int led_fall    = 0;
	logic pu_q      = 1'b0;
	logic strb_q    = 1'b0;
	logic align_q   = 1'b0;
	logic led_q     = 1'b0;

	adc_timing_top uut (
		.fastClk         (fastClk),
		.rst_n           (rst_n),
		.ring_clk        (ring_clk),
		.ring_edge_sel   (ring_edge_sel),
		.use_ext_ring    (use_ext_ring),
		.trig            (trig),
		.sync_period     (sync_period),
		.trig_delay      (trig_delay),
		.sample_hold_off (sample_hold_off),
		.num_smpls       (num_smpls),
		.store_strb      (store_strb),
		.adc_powerup     (adc_powerup),
		.adc_align_en    (adc_align_en),
		.trig_led        (trig_led),
		.ring_led        (ring_led)
	);

	always #(CLK_NS / 2) fastClk = ~fastClk;

	//////////////////////////////////////////////////////////////////////
	// ring clock and output monitor
	//////////////////////////////////////////////////////////////////////

	// parked at rest level until released, then random half periods
	// control flags taken on the rising edge, pin moves with the other inputs
	initial begin
		logic run_now;
		logic rest_now;
		ring_clk = 1'b0;
		forever begin
			@(posedge fastClk);
			run_now  = ring_run;
			rest_now = ring_rest;
			#10;
			if (!run_now) begin
				ring_clk  = rest_now;
				ring_left = 0;
			end else if (ring_left == 0) begin
				ring_clk  = ~ring_clk;
				ring_left = 1 + ($unsigned($random(seed)) % 5);
			end else begin
				ring_left = ring_left - 1;
			end
		end
	end

	// rise and fall cycle of every measured output
	// sampled mid-cycle on the falling edge
	always @(negedge fastClk) begin
		cyc = cyc + 1;
		if (adc_powerup && !pu_q) pu_rise = cyc;
		if (!adc_powerup && pu_q) pu_fall = cyc;
		if (store_strb && !strb_q) begin
			strb_rise   = cyc;
			strb_pulses = strb_pulses + 1;
		end
		if (!store_strb && strb_q) strb_fall = cyc;
		if (adc_align_en && !align_q) align_rise = cyc;
		if (!adc_align_en && align_q) align_fall = cyc;
		if (trig_led && !led_q) led_rise = cyc;
		if (!trig_led && led_q) led_fall = cyc;
		pu_q    = adc_powerup;
		strb_q  = store_strb;
		align_q = adc_align_en;
		led_q   = trig_led;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge fastClk);
		#10;
	endtask

	task automatic compare_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic add_row(input int idx, input string name, input int ext, input int sel,
		input int period, input int delay, input int hold, input int smpls);
		row_name[idx]   = name;
		row_ext[idx]    = ext;
		row_sel[idx]    = sel;
		row_period[idx] = period;
		row_delay[idx]  = delay;
		row_hold[idx]   = hold;
		row_smpls[idx]  = smpls;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) next_cycle();
		rst_n = 1'b1;
	endtask

	task automatic pulse_trig();
		trig = 1'b1;
		next_cycle();
		trig = 1'b0;
	endtask

	// budget per row from the longest delay in the table
	initial begin
		longint budget_ns;
		int     max_delay;
		max_delay = 0;
		#1;
		for (int r = 0; r < NROWS; r++) begin
			if (row_delay[r] > max_delay) max_delay = row_delay[r];
		end
		budget_ns = longint'(NROWS) * CLK_NS * (max_delay * 257 + `SEQ_WARMUP_CYCLES
			+ 1200 + `SEQ_ALIGN_CYCLES + 200);
		#(budget_ns);
		$display("ERROR: simulation timed out, a sequence never finished");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		string name;
		int    p;
		int    lo;
		int    hi;
		int    d;
		int    trig_cyc;
		int    row_start;
		int    pulses_before;
		logic  do_reset;
		rst_n           = 1'b0;
		trig            = 1'b0;
		use_ext_ring    = 1'b0;
		ring_edge_sel   = 1'b0;
		sync_period     = '0;
		trig_delay      = '0;
		sample_hold_off = '0;
		num_smpls       = '0;
		//         name              ext sel period delay hold smpls
		add_row(0, "int_d0_p3",      0,  1,  3,     0,    0,   8);
		add_row(1, "int_d5_p9",      0,  1,  9,     5,    17,  100);
		add_row(2, "int_d2_p9_h127", 0,  0,  9,     2,    127, 1);
		add_row(3, "ext_rise_d3",    1,  1,  20,    3,    5,   33);
		add_row(4, "ext_fall_d1",    1,  0,  50,    1,    64,  1023);
		add_row(5, "int_d4_p255",    0,  1,  255,   4,    2,   12);
		for (int r = 0; r < NROWS; r++) begin
			name = row_name[r];
			p    = row_period[r] + 1;
			// new period or ring mode needs a clean ring_sync start
			if (r == 0) begin
				do_reset = 1'b1;
			end else begin
				do_reset = (row_ext[r] != 0) || (row_ext[r-1] != 0)
					|| (row_period[r] != row_period[r-1]);
			end
			use_ext_ring    = (row_ext[r] != 0);
			ring_edge_sel   = (row_sel[r] != 0);
			sync_period     = sync_period_t'(row_period[r]);
			trig_delay      = trig_delay_t'(row_delay[r]);
			sample_hold_off = hold_off_t'(row_hold[r]);
			num_smpls       = num_smpls_t'(row_smpls[r]);
			// first toggle from rest is the selected edge
			ring_rest = ~ring_edge_sel;
			if (do_reset) begin
				apply_reset();
				compare_value({name, " ring_led after reset"}, 0, int'(ring_led));
			end
			compare_value({name, " store_strb idle"}, 0, int'(store_strb));
			compare_value({name, " adc_powerup idle"}, 0, int'(adc_powerup));
			compare_value({name, " adc_align_en idle"}, 0, int'(adc_align_en));
			compare_value({name, " trig_led idle"}, 0, int'(trig_led));
			row_start = cyc;
			trig_cyc  = cyc + 1;
			pulse_trig();
			if (row_ext[r] != 0) begin
				// nothing may move before the ring starts
				// window outlasts one full sync period
				repeat (p + QUIET_CYCLES) begin
					next_cycle();
					compare_value({name, " ring_led before ring edge"}, 0, int'(ring_led));
					compare_value({name, " adc_powerup before ring edge"}, 0,
						int'(adc_powerup));
				end
				ring_run = 1'b1;
			end
			while (pu_rise <= row_start) next_cycle();
			if (row_ext[r] == 0) begin
				// whole sync periods plus a few cycles of pipeline
				d  = pu_rise - trig_cyc;
				lo = row_delay[r] * p;
				hi = (row_delay[r] + 1) * p + 4;
				compare_value({name, " power-up delay"},
					(d < lo) ? lo : ((d > hi) ? hi : d), d);
			end
			// trigger led from the first trig
			while (led_fall <= row_start) next_cycle();
			compare_value({name, " trig_led start"}, trig_cyc + 1, led_rise);
			compare_value({name, " trig_led length"}, `SEQ_LED_CYCLES, led_fall - led_rise);
			// retrigger inside warm-up must be ignored
			while (cyc < pu_rise + 100) next_cycle();
			pulses_before = strb_pulses;
			pulse_trig();
			while (pu_fall <= row_start) next_cycle();
			compare_value({name, " store_strb pulses"}, 1, strb_pulses - pulses_before);
			compare_value({name, " store_strb start"},
				`SEQ_WARMUP_CYCLES + row_hold[r] + 3, strb_rise - pu_rise);
			compare_value({name, " store_strb length"}, row_smpls[r], strb_fall - strb_rise);
			compare_value({name, " align start"}, 1, align_rise - strb_fall);
			compare_value({name, " align length"}, `SEQ_ALIGN_CYCLES + 1,
				align_fall - align_rise);
			compare_value({name, " power-down with align"}, align_fall, pu_fall);
			repeat (5) next_cycle();
			ring_run = 1'b0;
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

/* flist.f */
+incdir+.
adc_timing_pkg.sv
adc_phase_if.sv
ring_sync.sv
trig_sequencer.sv
sample_window.sv
align_timer.sv
led_stretch.sv
adc_timing_top.sv
tb_adc_timing.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_adc_timing -f flist.f -o sim_tb \
	&& ./obj_dir/sim_tb \
	|| { echo "simulation failed"; exit 1; }
